//--- noc_addr_rule_table.sv
////////////////////////////////////////
// Address rule table of the route stage
// Register storage, written by a config strobe
////////////////////////////////////////

`timescale 1ns/1ps

module noc_addr_rule_table #(
  parameter int unsigned NumRules = 4
) (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic                                     cfg_we_i,
  input  logic [noc_pkg::IdxWidth-1:0]             cfg_idx_i,
  input  logic [noc_pkg::AddrWidth-1:0]            cfg_start_i,
  input  logic [noc_pkg::AddrWidth-1:0]            cfg_end_i,
  input  logic [noc_pkg::CoordWidth-1:0]           cfg_x_i,
  input  logic [noc_pkg::CoordWidth-1:0]           cfg_y_i,
  input  logic                                     cfg_valid_i,
  output logic [NumRules*noc_pkg::AddrWidth-1:0]   rule_start_o,
  output logic [NumRules*noc_pkg::AddrWidth-1:0]   rule_end_o,
  output logic [NumRules*noc_pkg::CoordWidth-1:0]  rule_x_o,
  output logic [NumRules*noc_pkg::CoordWidth-1:0]  rule_y_o,
  output logic [NumRules-1:0]                      rule_valid_o
);

  import noc_pkg::*;

  // Per-rule storage, the range is start inclusive and end exclusive
  logic [AddrWidth-1:0]  start_q [NumRules];
  logic [AddrWidth-1:0]  end_q   [NumRules];
  logic [CoordWidth-1:0] x_q     [NumRules];
  logic [CoordWidth-1:0] y_q     [NumRules];
  logic [NumRules-1:0]   valid_q;

  // One-hot write enable per rule
  // An index at or above NumRules matches no entry and the write is dropped
  logic [NumRules-1:0]   wr_en;

  always_comb begin
    for (int i = 0; i < NumRules; i++) begin
      wr_en[i] = cfg_we_i && (cfg_idx_i == IdxWidth'(i));
    end
  end

  // After reset every rule is invalid, so all requests decode to an error
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else begin
      for (int i = 0; i < NumRules; i++) begin
        if (wr_en[i]) begin
          valid_q[i] <= cfg_valid_i;
        end
      end
    end
  end

  // Range and destination fields are only meaningful while the valid bit is set
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NumRules; i++) begin
      if (wr_en[i]) begin
        start_q[i] <= cfg_start_i;
        end_q[i]   <= cfg_end_i;
        x_q[i]     <= cfg_x_i;
        y_q[i]     <= cfg_y_i;
      end
    end
  end

  // Flatten the table so the decoder sees it combinationally
  for (genvar i = 0; i < NumRules; i++) begin : gen_flat
    assign rule_start_o[i*AddrWidth +: AddrWidth]  = start_q[i];
    assign rule_end_o[i*AddrWidth +: AddrWidth]    = end_q[i];
    assign rule_x_o[i*CoordWidth +: CoordWidth]    = x_q[i];
    assign rule_y_o[i*CoordWidth +: CoordWidth]    = y_q[i];
  end

  assign rule_valid_o = valid_q;

endmodule

//--- noc_pkg.sv
////////////////////////////////////////
// Widths and limits shared by the route stage
// Output direction encoding of the local router
////////////////////////////////////////

package noc_pkg;

  // Width of a physical request address
  localparam int unsigned AddrWidth = 32;

  // Width of one mesh coordinate, two bits span a 4 by 4 mesh
  localparam int unsigned CoordWidth = 2;

  // Upper bound on the number of address rules in the table
  localparam int unsigned MaxRules = 8;

  // Width of a rule index on the configuration port
  localparam int unsigned IdxWidth = $clog2(MaxRules);

  // Output port of the local router chosen by the XY stage
  typedef enum logic [2:0] {
    DIR_LOCAL = 3'd0,
    DIR_NORTH = 3'd1,
    DIR_EAST  = 3'd2,
    DIR_SOUTH = 3'd3,
    DIR_WEST  = 3'd4
  } route_dir_e;

endpackage

//--- noc_route_checker.sv
////////////////////////////////////////
// Scoreboard of the route stage
// Rule model, expectation queue, compare
////////////////////////////////////////

`timescale 1ns/1ps

module noc_route_checker #(
  parameter int unsigned NumRules = 4,
  parameter int unsigned MyX      = 1,
  parameter int unsigned MyY      = 2
) (
  input logic                           clk_i,
  input logic                           rst_n_i,
  input logic                           req_valid_i,
  input logic                           out_valid_i,
  input noc_pkg::route_dir_e            out_dir_i,
  input logic [noc_pkg::CoordWidth-1:0] out_dst_x_i,
  input logic [noc_pkg::CoordWidth-1:0] out_dst_y_i,
  input logic                           out_err_i
);

  import noc_pkg::*;

  localparam int TileX = int'(MyX);
  localparam int TileY = int'(MyY);

  // Reference copy of the rule table, all rules start out invalid
  logic [AddrWidth-1:0]  m_start [MaxRules];
  logic [AddrWidth-1:0]  m_end   [MaxRules];
  logic [CoordWidth-1:0] m_x     [MaxRules];
  logic [CoordWidth-1:0] m_y     [MaxRules];
  bit                    m_valid [MaxRules] = '{default: 1'b0};

  // Predicted results in request order, plus the cycle of each strobe
  string                 exp_name_q [$];
  route_dir_e            exp_dir_q  [$];
  logic [CoordWidth-1:0] exp_x_q    [$];
  logic [CoordWidth-1:0] exp_y_q    [$];
  logic                  exp_err_q  [$];
  int unsigned           stamp_q    [$];

  int unsigned cyc            = 0;
  int          mismatch_count = 0;
  int          protocol_count = 0;
  int          model_count    = 0;

  // Writes to an index beyond the table are dropped, as in the DUT
  task automatic record_write(input int idx, input logic [AddrWidth-1:0] start_a, end_a,
                              input logic [CoordWidth-1:0] x, y, input logic valid);
    if (idx < int'(NumRules)) begin
      m_start[idx] = start_a;
      m_end[idx]   = end_a;
      m_x[idx]     = x;
      m_y[idx]     = y;
      m_valid[idx] = valid;
    end
  endtask

  // First valid rule with start <= addr < end wins, then X before Y
  task automatic predict(input logic [AddrWidth-1:0] addr, output route_dir_e dir,
                         output logic [CoordWidth-1:0] x, y, output logic err);
    bit found;
    found = 1'b0;
    x     = '0;
    y     = '0;
    for (int i = 0; i < int'(NumRules); i++) begin
      if (!found && m_valid[i] && addr >= m_start[i] && addr < m_end[i]) begin
        found = 1'b1;
        x     = m_x[i];
        y     = m_y[i];
      end
    end
    err = !found;
    if (err) dir = DIR_LOCAL;
    else if (int'(x) > TileX) dir = DIR_EAST;
    else if (int'(x) < TileX) dir = DIR_WEST;
    else if (int'(y) > TileY) dir = DIR_NORTH;
    else if (int'(y) < TileY) dir = DIR_SOUTH;
    else dir = DIR_LOCAL;
  endtask

  // The data file row must agree with the model before it is queued
  task automatic expect_result(input string name, input logic [AddrWidth-1:0] addr,
                               input route_dir_e dir, input logic [CoordWidth-1:0] x, y,
                               input logic err);
    route_dir_e            p_dir;
    logic [CoordWidth-1:0] p_x;
    logic [CoordWidth-1:0] p_y;
    logic                  p_err;
    predict(addr, p_dir, p_x, p_y, p_err);
    if (p_dir != dir || p_x != x || p_y != y || p_err != err) begin
      model_count++;
      $display("Data file row %s disagrees with the rule model (dir %s x %0d y %0d err %0b)",
               name, p_dir.name(), p_x, p_y, p_err);
    end
    exp_name_q.push_back(name);
    exp_dir_q.push_back(p_dir);
    exp_x_q.push_back(p_x);
    exp_y_q.push_back(p_y);
    exp_err_q.push_back(p_err);
  endtask

  task automatic compare_value(input string name, input string field, input int exp_v,
                               input int act_v);
    if (exp_v != act_v) begin
      mismatch_count++;
      $display("MISMATCH %s %s expected %0d actual %0d", name, field, exp_v, act_v);
    end
  endtask

  // Pop the oldest prediction and compare every field of the beat
  task automatic check_beat();
    string       name;
    int unsigned stamp;
    route_dir_e  dir;
    if (exp_name_q.size() == 0 || stamp_q.size() == 0) begin
      protocol_count++;
      $display("Output beat in cycle %0d arrived with no request pending", cyc);
    end else begin
      name  = exp_name_q.pop_front();
      stamp = stamp_q.pop_front();
      dir   = exp_dir_q.pop_front();
      if (dir != out_dir_i) begin
        mismatch_count++;
        $display("MISMATCH %s dir expected %s actual %s", name, dir.name(), out_dir_i.name());
      end
      compare_value(name, "dst_x", int'(exp_x_q.pop_front()), int'(out_dst_x_i));
      compare_value(name, "dst_y", int'(exp_y_q.pop_front()), int'(out_dst_y_i));
      compare_value(name, "err", int'(exp_err_q.pop_front()), int'(out_err_i));
      compare_value(name, "latency", 2, int'(cyc - stamp));
    end
  endtask

  function automatic int pending_count();
    return exp_name_q.size();
  endfunction

  function automatic int report_leftovers();
    foreach (exp_name_q[i]) begin
      $display("Request %s never received a result from the DUT", exp_name_q[i]);
    end
    return exp_name_q.size();
  endfunction

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  // Sampled mid-cycle, where strobes and registered outputs are settled
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (req_valid_i) begin
        stamp_q.push_back(cyc);
      end
      if (out_valid_i) begin
        check_beat();
      end
    end
  end

endmodule

//--- noc_route_comp.sv
////////////////////////////////////////
// First-match address decode against the rule table
// Registered destination tile and error flag
////////////////////////////////////////

`timescale 1ns/1ps

module noc_route_comp #(
  parameter int unsigned NumRules = 4
) (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic                                     req_valid_i,
  input  logic [noc_pkg::AddrWidth-1:0]            req_addr_i,
  input  logic [NumRules*noc_pkg::AddrWidth-1:0]   rule_start_i,
  input  logic [NumRules*noc_pkg::AddrWidth-1:0]   rule_end_i,
  input  logic [NumRules*noc_pkg::CoordWidth-1:0]  rule_x_i,
  input  logic [NumRules*noc_pkg::CoordWidth-1:0]  rule_y_i,
  input  logic [NumRules-1:0]                      rule_valid_i,
  output logic                                     dec_valid_o,
  output logic [noc_pkg::CoordWidth-1:0]           dec_x_o,
  output logic [noc_pkg::CoordWidth-1:0]           dec_y_o,
  output logic                                     dec_err_o
);

  import noc_pkg::*;

  // Range hit per rule, independent of priority
  logic [NumRules-1:0]   match;

  // Result of the prioritized pick
  logic                  hit;
  logic [CoordWidth-1:0] hit_x;
  logic [CoordWidth-1:0] hit_y;

  // Decode stage registers
  logic                  dec_valid_q;
  logic [CoordWidth-1:0] dec_x_q;
  logic [CoordWidth-1:0] dec_y_q;
  logic                  dec_err_q;

  // A rule hits when it is valid and start <= addr < end
  for (genvar i = 0; i < NumRules; i++) begin : gen_match
    assign match[i] = rule_valid_i[i] &&
                      (req_addr_i >= rule_start_i[i*AddrWidth +: AddrWidth]) &&
                      (req_addr_i <  rule_end_i[i*AddrWidth +: AddrWidth]);
  end

  // Walk the rules in index order, the lowest matching index wins
  // With no hit the destination stays at tile 0,0
  always_comb begin
    hit   = 1'b0;
    hit_x = '0;
    hit_y = '0;
    for (int i = 0; i < NumRules; i++) begin
      if (!hit && match[i]) begin
        hit   = 1'b1;
        hit_x = rule_x_i[i*CoordWidth +: CoordWidth];
        hit_y = rule_y_i[i*CoordWidth +: CoordWidth];
      end
    end
  end

  // The strobe advances one cycle, there is no stall
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dec_valid_q <= 1'b0;
    end else begin
      dec_valid_q <= req_valid_i;
    end
  end

  // Payload is captured only alongside a request strobe
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      dec_x_q   <= hit_x;
      dec_y_q   <= hit_y;
      dec_err_q <= !hit;
    end
  end

  assign dec_valid_o = dec_valid_q;
  assign dec_x_o     = dec_x_q;
  assign dec_y_o     = dec_y_q;
  assign dec_err_o   = dec_err_q;

endmodule

//--- noc_route_sva.sv
////////////////////////////////////////
// Concurrent assertions on the route top
// Bound into noc_route_top
////////////////////////////////////////

`timescale 1ns/1ps

module noc_route_sva (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                req_valid_i,
  input logic                out_valid_i,
  input noc_pkg::route_dir_e out_dir_i,
  input logic                out_err_i
);

  import noc_pkg::*;

  // Number of assertion failures seen so far
  int unsigned fail_count = 0;

  // Two register stages and no stall, so every strobe comes back two edges later
  a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i == $past(req_valid_i, 2))
    else begin
      fail_count++;
      $error("out_valid_o does not follow req_valid_i by two cycles");
    end

  // Synchronous reset clears the output strobe one edge after it is seen
  a_reset_clear: assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_i)
    else begin
      fail_count++;
      $error("out_valid_o is high while reset is asserted");
    end

  // A decode miss is always delivered to the local port
  a_err_local: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_i && out_err_i) |-> out_dir_i == DIR_LOCAL)
    else begin
      fail_count++;
      $error("Errored result does not carry DIR_LOCAL");
    end

endmodule

bind noc_route_top noc_route_sva i_route_sva (
  .clk_i       ( clk_i       ),
  .rst_n_i     ( rst_n_i     ),
  .req_valid_i ( req_valid_i ),
  .out_valid_i ( out_valid_o ),
  .out_dir_i   ( out_dir_o   ),
  .out_err_i   ( out_err_o   )
);

//--- noc_route_tb.sv
////////////////////////////////////////
// Testbench top of the route stage
// Clock, reset, data file reader, stimulus
////////////////////////////////////////

`timescale 1ns/1ps

module noc_route_tb;

  import noc_pkg::*;

  localparam int unsigned NumRules = 4;
  localparam int unsigned MyX      = 1;
  localparam int unsigned MyY      = 2;
  // Cycles allowed for the pipeline to return the last results
  localparam int          DrainLimit = 50;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  cfg_we;
  logic [IdxWidth-1:0]   cfg_idx;
  logic [AddrWidth-1:0]  cfg_start;
  logic [AddrWidth-1:0]  cfg_end;
  logic [CoordWidth-1:0] cfg_x;
  logic [CoordWidth-1:0] cfg_y;
  logic                  cfg_valid;
  logic                  req_valid;
  logic [AddrWidth-1:0]  req_addr;
  logic                  out_valid;
  route_dir_e            out_dir;
  logic [CoordWidth-1:0] out_dst_x;
  logic [CoordWidth-1:0] out_dst_y;
  logic                  out_err;

  int seed      = 32'h396;
  int tb_errors = 0;
  int timeouts  = 0;

  always #10 clk = ~clk;

  noc_route_top #(.NumRules(NumRules), .MyX(MyX), .MyY(MyY)) dut0 (
    .clk_i       ( clk       ), .rst_n_i     ( rst_n     ),
    .cfg_we_i    ( cfg_we    ), .cfg_idx_i   ( cfg_idx   ),
    .cfg_start_i ( cfg_start ), .cfg_end_i   ( cfg_end   ),
    .cfg_x_i     ( cfg_x     ), .cfg_y_i     ( cfg_y     ),
    .cfg_valid_i ( cfg_valid ), .req_valid_i ( req_valid ),
    .req_addr_i  ( req_addr  ), .out_valid_o ( out_valid ),
    .out_dir_o   ( out_dir   ), .out_dst_x_o ( out_dst_x ),
    .out_dst_y_o ( out_dst_y ), .out_err_o   ( out_err   )
  );

  noc_route_checker #(.NumRules(NumRules), .MyX(MyX), .MyY(MyY)) chk0 (
    .clk_i       ( clk       ), .rst_n_i     ( rst_n     ),
    .req_valid_i ( req_valid ), .out_valid_i ( out_valid ),
    .out_dir_i   ( out_dir   ), .out_dst_x_i ( out_dst_x ),
    .out_dst_y_i ( out_dst_y ), .out_err_i   ( out_err   )
  );

  task automatic idle_cycle();
    @(posedge clk);
    #2;
    cfg_we    = 1'b0;
    req_valid = 1'b0;
  endtask

  // One configuration strobe, mirrored into the checker's rule model
  task automatic drive_write(input int idx, input logic [AddrWidth-1:0] s, e,
                             input int x, y, v);
    @(posedge clk);
    #2;
    req_valid = 1'b0;
    cfg_we    = 1'b1;
    cfg_idx   = IdxWidth'(idx);
    cfg_start = s;
    cfg_end   = e;
    cfg_x     = CoordWidth'(x);
    cfg_y     = CoordWidth'(y);
    cfg_valid = (v != 0);
    chk0.record_write(idx, s, e, CoordWidth'(x), CoordWidth'(y), v != 0);
  endtask

  task automatic drive_request(input string name, input logic [AddrWidth-1:0] addr,
                               input route_dir_e dir, input int x, y, err);
    @(posedge clk);
    #2;
    cfg_we    = 1'b0;
    req_valid = 1'b1;
    req_addr  = addr;
    chk0.expect_result(name, addr, dir, CoordWidth'(x), CoordWidth'(y), err != 0);
  endtask

  task automatic decode_dir(input string s, output route_dir_e d, output bit ok);
    ok = 1'b1;
    case (s)
      "L": d = DIR_LOCAL;
      "N": d = DIR_NORTH;
      "E": d = DIR_EAST;
      "S": d = DIR_SOUTH;
      "W": d = DIR_WEST;
      default: begin
        d  = DIR_LOCAL;
        ok = 1'b0;
      end
    endcase
  endtask

  // A gap of 0 to 2 idle cycles goes before every request, zero gives back-to-back strobes
  task automatic run_line(input string line);
    int                   idx, x, y, v, n, gap;
    logic [AddrWidth-1:0] a, b;
    string                name, dir_s;
    route_dir_e           dir;
    bit                   ok;
    if (line.len() < 2 || line.getc(0) == "#") return;
    if (line.getc(0) == "W") begin
      n = $sscanf(line, "W %d %h %h %d %d %d", idx, a, b, x, y, v);
      if (n == 6) drive_write(idx, a, b, x, y, v);
      else ok = 1'b0;
    end else if (line.getc(0) == "R") begin
      n = $sscanf(line, "R %s %h %s %d %d %d", name, a, dir_s, x, y, v);
      decode_dir(dir_s, dir, ok);
      if (n == 6 && ok) begin
        gap = {$random(seed)} % 3;
        repeat (gap) idle_cycle();
        drive_request(name, a, dir, x, y, v);
      end else ok = 1'b0;
    end else ok = 1'b0;
    if (!ok && line.getc(0) != "W") begin
      tb_errors++;
      $display("Could not parse data file line: %s", line);
    end else if (line.getc(0) == "W" && n != 6) begin
      tb_errors++;
      $display("Could not parse data file line: %s", line);
    end
  endtask

  initial begin
    int    fd, waited, leftovers, total, sva_fails;
    string line;
    rst_n     = 1'b0;
    cfg_we    = 1'b0;
    cfg_idx   = '0;
    cfg_start = '0;
    cfg_end   = '0;
    cfg_x     = '0;
    cfg_y     = '0;
    cfg_valid = 1'b0;
    req_valid = 1'b0;
    req_addr  = '0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    fd = $fopen("noc_route_tests.txt", "r");
    if (fd == 0) begin
      tb_errors++;
      $display("Could not open the data file noc_route_tests.txt");
    end else begin
      while ($fgets(line, fd) != 0) run_line(line);
      $fclose(fd);
    end
    idle_cycle();
    // Wait for every queued prediction to be answered, bounded by DrainLimit
    waited = 0;
    while (chk0.pending_count() != 0 && waited < DrainLimit) begin
      @(posedge clk);
      waited++;
    end
    if (chk0.pending_count() != 0) begin
      timeouts++;
      $display("Timed out after %0d cycles waiting for the DUT to return results", DrainLimit);
    end
    // A few quiet cycles so a stray extra beat is still caught
    repeat (4) @(posedge clk);
    leftovers = chk0.report_leftovers();
    sva_fails = int'(dut0.i_route_sva.fail_count);
    total = chk0.mismatch_count + chk0.protocol_count + chk0.model_count + leftovers +
            timeouts + tb_errors + sva_fails;
    $write("Errors: mismatch %0d, protocol %0d, model %0d, pending %0d, ",
           chk0.mismatch_count, chk0.protocol_count, chk0.model_count, leftovers);
    $display("timeout %0d, tb %0d, assertion %0d", timeouts, tb_errors, sva_fails);
    if (total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- noc_route_tests.txt
# W idx start_hex end_hex dst_x dst_y valid
# R name addr_hex dir(L N E S W) dst_x dst_y err
R noinit_a 00000000 L 0 0 1
R noinit_b 80001000 L 0 0 1
W 0 00001000 00002000 3 2 1
W 1 00002000 00003000 0 2 1
W 2 00003000 00004000 1 3 1
W 3 00000000 00010000 1 0 1
R east_lo 00001000 E 3 2 0
R east_top 00001FFF E 3 2 0
R west_mid 00002800 W 0 2 0
R north_lo 00003000 N 1 3 0
R south_end 00004000 S 1 0 0
R low_r3 00000FFF S 1 0 0
R range_end 00010000 L 0 0 1
W 3 00000000 00010000 1 2 1
R local_hit 00005000 L 1 2 0
W 0 00001000 00002000 3 2 0
R cleared_r0 00001800 L 1 2 0
W 1 00002000 00003000 0 3 1
R west_first 00002000 W 0 3 0
W 2 00003000 00004000 2 0 1
R east_first 00003FFF E 2 0 0
W 5 00020000 00030000 2 2 1
R idx_ignored 00020000 L 0 0 1
W 0 00001000 00002000 1 1 1
R rewrite_r0 00001800 S 1 1 0
R burst_a 00002004 W 0 3 0
R burst_b 00003004 E 2 0 0
R burst_c 00000004 L 1 2 0
R burst_d FFFFFFFF L 0 0 1
R burst_e 00001004 S 1 1 0

//--- noc_route_top.sv
////////////////////////////////////////
// Route computation top of one mesh tile
// Rule table, address decoder, XY stage
////////////////////////////////////////

`timescale 1ns/1ps

module noc_route_top #(
  parameter int unsigned NumRules = 4,
  parameter int unsigned MyX      = 1,
  parameter int unsigned MyY      = 2
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            cfg_we_i,
  input  logic [noc_pkg::IdxWidth-1:0]    cfg_idx_i,
  input  logic [noc_pkg::AddrWidth-1:0]   cfg_start_i,
  input  logic [noc_pkg::AddrWidth-1:0]   cfg_end_i,
  input  logic [noc_pkg::CoordWidth-1:0]  cfg_x_i,
  input  logic [noc_pkg::CoordWidth-1:0]  cfg_y_i,
  input  logic                            cfg_valid_i,
  input  logic                            req_valid_i,
  input  logic [noc_pkg::AddrWidth-1:0]   req_addr_i,
  output logic                            out_valid_o,
  output noc_pkg::route_dir_e             out_dir_o,
  output logic [noc_pkg::CoordWidth-1:0]  out_dst_x_o,
  output logic [noc_pkg::CoordWidth-1:0]  out_dst_y_o,
  output logic                            out_err_o
);

  import noc_pkg::*;

  // Flattened rule table, one slice per rule
  logic [NumRules*AddrWidth-1:0]  rule_start;
  logic [NumRules*AddrWidth-1:0]  rule_end;
  logic [NumRules*CoordWidth-1:0] rule_x;
  logic [NumRules*CoordWidth-1:0] rule_y;
  logic [NumRules-1:0]            rule_valid;

  // Decode stage result towards the XY stage
  logic                           dec_valid;
  logic [CoordWidth-1:0]          dec_x;
  logic [CoordWidth-1:0]          dec_y;
  logic                           dec_err;

  noc_addr_rule_table #(
    .NumRules     ( NumRules    )
  ) i_rule_table (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .cfg_we_i     ( cfg_we_i    ),
    .cfg_idx_i    ( cfg_idx_i   ),
    .cfg_start_i  ( cfg_start_i ),
    .cfg_end_i    ( cfg_end_i   ),
    .cfg_x_i      ( cfg_x_i     ),
    .cfg_y_i      ( cfg_y_i     ),
    .cfg_valid_i  ( cfg_valid_i ),
    .rule_start_o ( rule_start  ),
    .rule_end_o   ( rule_end    ),
    .rule_x_o     ( rule_x      ),
    .rule_y_o     ( rule_y      ),
    .rule_valid_o ( rule_valid  )
  );

  // First pipeline stage, address to destination tile
  noc_route_comp #(
    .NumRules     ( NumRules    )
  ) i_route_comp (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .req_valid_i  ( req_valid_i ),
    .req_addr_i   ( req_addr_i  ),
    .rule_start_i ( rule_start  ),
    .rule_end_i   ( rule_end    ),
    .rule_x_i     ( rule_x      ),
    .rule_y_i     ( rule_y      ),
    .rule_valid_i ( rule_valid  ),
    .dec_valid_o  ( dec_valid   ),
    .dec_x_o      ( dec_x       ),
    .dec_y_o      ( dec_y       ),
    .dec_err_o    ( dec_err     )
  );

  // Second pipeline stage, destination tile to router port
  noc_xy_dir_sel #(
    .MyX          ( MyX         ),
    .MyY          ( MyY         )
  ) i_dir_sel (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .dec_valid_i  ( dec_valid   ),
    .dec_x_i      ( dec_x       ),
    .dec_y_i      ( dec_y       ),
    .dec_err_i    ( dec_err     ),
    .out_valid_o  ( out_valid_o ),
    .out_dir_o    ( out_dir_o   ),
    .out_dst_x_o  ( out_dst_x_o ),
    .out_dst_y_o  ( out_dst_y_o ),
    .out_err_o    ( out_err_o   )
  );

endmodule

//--- noc_xy_dir_sel.sv
////////////////////////////////////////
// Dimension-ordered XY direction select
// Registered output stage of the route pipeline
////////////////////////////////////////

`timescale 1ns/1ps

module noc_xy_dir_sel #(
  parameter int unsigned MyX = 1,
  parameter int unsigned MyY = 2
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            dec_valid_i,
  input  logic [noc_pkg::CoordWidth-1:0]  dec_x_i,
  input  logic [noc_pkg::CoordWidth-1:0]  dec_y_i,
  input  logic                            dec_err_i,
  output logic                            out_valid_o,
  output noc_pkg::route_dir_e             out_dir_o,
  output logic [noc_pkg::CoordWidth-1:0]  out_dst_x_o,
  output logic [noc_pkg::CoordWidth-1:0]  out_dst_y_o,
  output logic                            out_err_o
);

  import noc_pkg::*;

  // Coordinates of this tile at coordinate width
  localparam logic [CoordWidth-1:0] MyXCoord = CoordWidth'(MyX);
  localparam logic [CoordWidth-1:0] MyYCoord = CoordWidth'(MyY);

  route_dir_e            dir_d;

  logic                  out_valid_q;
  route_dir_e            out_dir_q;
  logic [CoordWidth-1:0] out_x_q;
  logic [CoordWidth-1:0] out_y_q;
  logic                  out_err_q;

  // X is resolved first, Y only once the column matches
  // Y grows towards north
  always_comb begin
    if (dec_err_i) begin
      dir_d = DIR_LOCAL;
    end else if (dec_x_i > MyXCoord) begin
      dir_d = DIR_EAST;
    end else if (dec_x_i < MyXCoord) begin
      dir_d = DIR_WEST;
    end else if (dec_y_i > MyYCoord) begin
      dir_d = DIR_NORTH;
    end else if (dec_y_i < MyYCoord) begin
      dir_d = DIR_SOUTH;
    end else begin
      dir_d = DIR_LOCAL;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
    end else begin
      out_valid_q <= dec_valid_i;
    end
  end

  // Destination and error travel with the direction
  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      out_dir_q <= dir_d;
      out_x_q   <= dec_x_i;
      out_y_q   <= dec_y_i;
      out_err_q <= dec_err_i;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_dir_o   = out_dir_q;
  assign out_dst_x_o = out_x_q;
  assign out_dst_y_o = out_y_q;
  assign out_err_o   = out_err_q;

endmodule

//--- run.sh
#!/bin/sh
# Build the route stage testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module noc_route_tb -f src.f \
  > build.log 2>&1 || { cat build.log; echo "Verilator build error"; exit 1; }
./obj_dir/Vnoc_route_tb > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0

//--- src.f
noc_pkg.sv
noc_addr_rule_table.sv
noc_route_comp.sv
noc_xy_dir_sel.sv
noc_route_top.sv
noc_route_sva.sv
noc_route_checker.sv
noc_route_tb.sv
